// File: common/battleship_settings.svh
// Board, fleet, ship length and report field sizes
`ifndef BATTLESHIP_SETTINGS_SVH
`define BATTLESHIP_SETTINGS_SVH

// Board geometry
`define BOARD_DIM 10
`define COORD_W 4

// Fleet makeup, largest ship first
`define FLEET_SIZE 5
`define SHIP_IDX_W 3
`define SHIP_LEN_W 3
`define SHIP_SIZE_0 5
`define SHIP_SIZE_1 4
`define SHIP_SIZE_2 3
`define SHIP_SIZE_3 3
`define SHIP_SIZE_4 2

// Report word is code, row, column, player, sunk
`define REPORT_W 12

`endif

// File: common/battleship_pkg.sv
// Cell, report-code and controller-state enums, and the ship length lookup
`default_nettype none

`include "battleship_settings.svh"

package battleship_pkg;

    // Contents of one board cell
    typedef enum logic [1:0] {
        CELL_EMPTY = 2'b00,
        CELL_MISS  = 2'b01,
        CELL_HIT   = 2'b10,
        CELL_SHIP  = 2'b11
    } cell_t;

    // Code field at the top of the report word
    typedef enum logic [1:0] {
        REPORT_REJECT = 2'b00,
        REPORT_MISS   = 2'b01,
        REPORT_HIT    = 2'b10,
        REPORT_PLACED = 2'b11
    } report_t;

    typedef enum logic [4:0] {
        ST_IDLE,
        ST_CHECK,
        ST_OVL,
        ST_PUT,
        ST_FETCH,
        ST_SUNK
    } ctrl_state_t;

    // Ship length by fleet index
    function automatic logic [`SHIP_LEN_W-1:0] ship_length(input logic [`SHIP_IDX_W-1:0] idx);
        case (idx)
            `SHIP_IDX_W'(0): return `SHIP_LEN_W'(`SHIP_SIZE_0);
            `SHIP_IDX_W'(1): return `SHIP_LEN_W'(`SHIP_SIZE_1);
            `SHIP_IDX_W'(2): return `SHIP_LEN_W'(`SHIP_SIZE_2);
            `SHIP_IDX_W'(3): return `SHIP_LEN_W'(`SHIP_SIZE_3);
            `SHIP_IDX_W'(4): return `SHIP_LEN_W'(`SHIP_SIZE_4);
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: board/board_mem.sv
// Board memory for one player, 10x10 cells of two bits each
`timescale 1ns/100ps
`default_nettype none

`include "battleship_settings.svh"

module board_mem
    import battleship_pkg::*;
(
    input  logic                ph1,
    input  logic                reset,
    input  logic                write_enable,
    input  logic [`COORD_W-1:0] row,
    input  logic [`COORD_W-1:0] col,
    input  cell_t               write_data,
    output cell_t               read_data
);

    localparam logic [`COORD_W-1:0] DIM = `COORD_W'(`BOARD_DIM);

    cell_t cells [`BOARD_DIM][`BOARD_DIM];

    always_ff @(posedge ph1)
    begin
        if (reset)
        begin
            for (int r = 0; r < `BOARD_DIM; r++)
                for (int c = 0; c < `BOARD_DIM; c++)
                    cells[r][c] <= CELL_EMPTY;
        end
        else if (write_enable)
            cells[row][col] <= write_data;
    end

    // Off-board addresses read as empty water
    assign read_data = (row < DIM && col < DIM) ? cells[row][col] : CELL_EMPTY;

    a_write_on_board: assert property (@(posedge ph1) disable iff (reset)
        write_enable |-> (row < DIM && col < DIM));

endmodule

`default_nettype wire

// File: board/ship_store.sv
// Ship record memory for one player, start row, start column and direction
`timescale 1ns/100ps
`default_nettype none

`include "battleship_settings.svh"

module ship_store (
    input  logic                   ph1,
    input  logic                   reset,
    input  logic                   write_enable,
    input  logic [`SHIP_IDX_W-1:0] ship_idx,
    input  logic [2*`COORD_W:0]    write_data,
    output logic [2*`COORD_W:0]    read_data
);

    localparam logic [`SHIP_IDX_W-1:0] FLEET = `SHIP_IDX_W'(`FLEET_SIZE);

    // Record layout is {row, col, direction}
    logic [2*`COORD_W:0] recs [`FLEET_SIZE];

    always_ff @(posedge ph1)
    begin
        if (reset)
        begin
            for (int i = 0; i < `FLEET_SIZE; i++)
                recs[i] <= '0;
        end
        else if (write_enable && ship_idx < FLEET)
            recs[ship_idx] <= write_data;
    end

    assign read_data = (ship_idx < FLEET) ? recs[ship_idx] : '0;

endmodule

`default_nettype wire

// File: logic/cell_walker.sv
// Cell walker that steps an address along the cells of one ship
`timescale 1ns/100ps
`default_nettype none

`include "battleship_settings.svh"

module cell_walker
    import battleship_pkg::*;
(
    input  logic                   ph1,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   stop,
    input  logic                   direction,
    input  logic [`COORD_W-1:0]    start_row,
    input  logic [`COORD_W-1:0]    start_col,
    input  logic [`SHIP_LEN_W-1:0] length,
    output logic [`COORD_W-1:0]    cur_row,
    output logic [`COORD_W-1:0]    cur_col,
    output logic                   last,
    output logic                   busy
);

    localparam logic [`COORD_W-1:0] EDGE = `COORD_W'(`BOARD_DIM - 1);

    logic                   dir;
    logic [`SHIP_LEN_W-1:0] remaining;

    assign last = busy && remaining == '0;

    always_ff @(posedge ph1)
    begin
        if (reset)
            busy <= 1'b0;
        else if (start)
            busy <= 1'b1;
        else if (stop || last)
            busy <= 1'b0;
    end

    // --------------------------------------------------
    // Address and count, loaded on start
    // --------------------------------------------------
    always_ff @(posedge ph1)
    begin
        if (start)
        begin
            cur_row   <= start_row;
            cur_col   <= start_col;
            dir       <= direction;
            remaining <= length - 1'b1;
        end
        else if (busy && !last)
        begin
            remaining <= remaining - 1'b1;
            // Horizontal ships extend in column
            if (dir)
                cur_col <= cur_col + 1'b1;
            else
                cur_row <= cur_row + 1'b1;
        end
    end

    a_step_on_board: assert property (@(posedge ph1) disable iff (reset)
        busy && !last |-> (dir ? cur_col < EDGE : cur_row < EDGE));

    a_legal_length: assert property (@(posedge ph1) disable iff (reset)
        start |-> (length != '0 && length <= ship_length('0)));

endmodule

`default_nettype wire

// File: logic/game_controller.sv
// Game FSM with move checks, turn tracking, sunk counting and report generation
`timescale 1ns/100ps
`default_nettype none

`include "battleship_settings.svh"

module game_controller
    import battleship_pkg::*;
(
    input  logic                   ph1,
    input  logic                   reset,
    input  logic                   read,
    input  logic                   player,
    input  logic                   direction,
    input  logic [`COORD_W-1:0]    row,
    input  logic [`COORD_W-1:0]    col,
    input  logic [`COORD_W-1:0]    walk_row,
    input  logic [`COORD_W-1:0]    walk_col,
    input  logic                   walk_last,
    input  logic                   walk_busy,
    input  cell_t                  cell_rd0,
    input  cell_t                  cell_rd1,
    input  logic [2*`COORD_W:0]    ship_rd0,
    input  logic [2*`COORD_W:0]    ship_rd1,
    output logic                   walk_start,
    output logic                   walk_stop,
    output logic                   walk_dir,
    output logic [`SHIP_LEN_W-1:0] walk_len,
    output logic [`COORD_W-1:0]    cell_row,
    output logic [`COORD_W-1:0]    cell_col,
    output logic                   cell_we0,
    output logic                   cell_we1,
    output cell_t                  cell_wd,
    output logic [`SHIP_IDX_W-1:0] ship_idx,
    output logic                   ship_we0,
    output logic                   ship_we1,
    output logic [2*`COORD_W:0]    ship_wd,
    output logic                   use_walker,
    output logic                   data_ready,
    output logic                   game_over,
    output logic [`REPORT_W-1:0]   data_out
);

    localparam logic [`COORD_W-1:0]    DIM       = `COORD_W'(`BOARD_DIM);
    localparam logic [`SHIP_IDX_W-1:0] LAST_SHIP = `SHIP_IDX_W'(`FLEET_SIZE - 1);
    localparam logic [`SHIP_IDX_W-1:0] FLEET     = `SHIP_IDX_W'(`FLEET_SIZE);

    ctrl_state_t state, state_next;

    // Latched move
    logic                   mv_player, mv_dir;
    logic [`COORD_W-1:0]    mv_row, mv_col;

    logic                   placing, turn;
    logic [`SHIP_IDX_W-1:0] next_ship, scan_idx, walk_cnt, total;
    logic [`SHIP_IDX_W-1:0] sunk_cnt [2];

    logic                   target, on_board, move_ok, shot_ok;
    logic                   ship_done, ship_we, put_we, shot_we;
    logic [`COORD_W:0]      ship_end;
    cell_t                  cell_rd_tgt;
    logic [2*`COORD_W:0]    rec;
    logic                   finish, fin_sunk;
    report_t                fin_code;

    // --------------------------------------------------
    // Move checks
    // --------------------------------------------------
    // Board under attention is the mover's while placing, the defender's while shooting
    assign target      = placing ? mv_player : ~mv_player;
    assign cell_rd_tgt = target ? cell_rd1 : cell_rd0;
    assign rec         = target ? ship_rd1 : ship_rd0;

    assign ship_idx = placing ? next_ship : scan_idx;
    assign walk_len = ship_length(ship_idx);
    assign on_board = mv_row < DIM && mv_col < DIM;
    assign ship_end = {1'b0, mv_dir ? mv_col : mv_row}
                    + {{(`COORD_W + 1 - `SHIP_LEN_W){1'b0}}, walk_len};

    assign move_ok = !game_over && mv_player == turn
                   && (placing ? (on_board && ship_end <= {1'b0, DIM}) : on_board);
    assign shot_ok = move_ok && !placing
                   && (cell_rd_tgt == CELL_EMPTY || cell_rd_tgt == CELL_SHIP);

    // Sunk scan moves on at the first intact ship cell or the end of the ship
    assign ship_done = cell_rd_tgt == CELL_SHIP || walk_last;
    assign total     = walk_cnt + {{(`SHIP_IDX_W - 1){1'b0}},
                                   walk_last && cell_rd_tgt != CELL_SHIP};

    // --------------------------------------------------
    // Memory and walker drive
    // --------------------------------------------------
    assign use_walker = state == ST_OVL || state == ST_PUT || state == ST_SUNK;
    assign cell_row   = (state == ST_FETCH) ? rec[2*`COORD_W:`COORD_W+1] : mv_row;
    assign cell_col   = (state == ST_FETCH) ? rec[`COORD_W:1] : mv_col;
    assign walk_dir   = (state == ST_FETCH) ? rec[0] : mv_dir;

    assign walk_start = (state == ST_CHECK && placing && move_ok)
                      || (state == ST_OVL && cell_rd_tgt == CELL_EMPTY && walk_last)
                      || state == ST_FETCH;
    assign walk_stop  = (state == ST_OVL && cell_rd_tgt != CELL_EMPTY)
                      || (state == ST_SUNK && cell_rd_tgt == CELL_SHIP);

    assign put_we   = state == ST_PUT && walk_busy;
    assign shot_we  = state == ST_CHECK && shot_ok;
    assign cell_we0 = (put_we || shot_we) && !target;
    assign cell_we1 = (put_we || shot_we) && target;
    assign cell_wd  = (state == ST_PUT) ? CELL_SHIP
                    : (cell_rd_tgt == CELL_SHIP ? CELL_HIT : CELL_MISS);

    assign ship_we  = state == ST_PUT && walk_last;
    assign ship_we0 = ship_we && !target;
    assign ship_we1 = ship_we && target;
    assign ship_wd  = {mv_row, mv_col, mv_dir};

    // --------------------------------------------------
    // Next state and report
    // --------------------------------------------------
    always_comb
    begin
        state_next = state;
        finish     = 1'b0;
        fin_code   = REPORT_REJECT;
        fin_sunk   = 1'b0;
        case (state)
            ST_IDLE:
                if (read)
                    state_next = ST_CHECK;
            ST_CHECK:
            begin
                if (!move_ok || (!placing && !shot_ok))
                begin
                    state_next = ST_IDLE;
                    finish     = 1'b1;
                end
                else if (placing)
                    state_next = ST_OVL;
                else if (cell_rd_tgt == CELL_SHIP)
                    state_next = ST_FETCH;
                else
                begin
                    state_next = ST_IDLE;
                    finish     = 1'b1;
                    fin_code   = REPORT_MISS;
                end
            end
            ST_OVL:
            begin
                // Overlap with an earlier ship
                if (cell_rd_tgt != CELL_EMPTY)
                begin
                    state_next = ST_IDLE;
                    finish     = 1'b1;
                end
                else if (walk_last)
                    state_next = ST_PUT;
            end
            ST_PUT:
                if (walk_last)
                begin
                    state_next = ST_IDLE;
                    finish     = 1'b1;
                    fin_code   = REPORT_PLACED;
                end
            ST_FETCH:
                state_next = ST_SUNK;
            ST_SUNK:
                if (ship_done && scan_idx == LAST_SHIP)
                begin
                    state_next = ST_IDLE;
                    finish     = 1'b1;
                    fin_code   = REPORT_HIT;
                    fin_sunk   = total > sunk_cnt[target];
                end
                else if (ship_done)
                    state_next = ST_FETCH;
            default:
                state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge ph1)
    begin
        if (reset)
        begin
            state       <= ST_IDLE;
            data_ready  <= 1'b0;
            game_over   <= 1'b0;
            placing     <= 1'b1;
            turn        <= 1'b0;
            next_ship   <= '0;
            sunk_cnt[0] <= '0;
            sunk_cnt[1] <= '0;
        end
        else
        begin
            state      <= state_next;
            data_ready <= finish;
            if (shot_we)
                turn <= ~turn;
            // Last ship of a player hands placement over, then shooting starts
            if (ship_we && next_ship == LAST_SHIP)
            begin
                next_ship <= '0;
                turn      <= ~turn;
                if (turn)
                    placing <= 1'b0;
            end
            else if (ship_we)
                next_ship <= next_ship + 1'b1;
            if (state == ST_SUNK && finish)
            begin
                sunk_cnt[target] <= total;
                if (total == FLEET)
                    game_over <= 1'b1;
            end
        end
    end

    always_ff @(posedge ph1)
    begin
        if (state == ST_IDLE && read)
        begin
            mv_player <= player;
            mv_dir    <= direction;
            mv_row    <= row;
            mv_col    <= col;
        end
        if (state == ST_CHECK)
        begin
            scan_idx <= '0;
            walk_cnt <= '0;
        end
        else if (state == ST_SUNK && ship_done)
        begin
            scan_idx <= scan_idx + 1'b1;
            walk_cnt <= total;
        end
        if (finish)
            data_out <= {fin_code, mv_row, mv_col, target, fin_sunk};
    end

    a_ready_pulse: assert property (@(posedge ph1) disable iff (reset)
        data_ready |=> !data_ready);

    a_no_write_on_reject: assert property (@(posedge ph1) disable iff (reset)
        finish && fin_code == REPORT_REJECT |-> !(cell_we0 || cell_we1));

    // Placement walks stay on the line of the move
    a_walk_on_line: assert property (@(posedge ph1) disable iff (reset)
        (state == ST_OVL || state == ST_PUT) && walk_busy
            |-> (mv_dir ? walk_row == mv_row : walk_col == mv_col));

endmodule

`default_nettype wire

// File: logic/battleship.sv
// Battleship referee top level with controller, walker and both players' memories
`timescale 1ns/100ps
`default_nettype none

`include "battleship_settings.svh"

module battleship
    import battleship_pkg::*;
(
    input  logic                 ph1,
    input  logic                 reset,
    input  logic                 read,
    input  logic                 player,
    input  logic                 direction,
    input  logic [`COORD_W-1:0]  row,
    input  logic [`COORD_W-1:0]  col,
    output logic                 data_ready,
    output logic                 game_over,
    output logic [`REPORT_W-1:0] data_out
);

    logic [`COORD_W-1:0]    walk_row, walk_col, cell_row, cell_col, mem_row, mem_col;
    logic                   walk_last, walk_busy, walk_start, walk_stop, walk_dir;
    logic [`SHIP_LEN_W-1:0] walk_len;
    logic                   use_walker, cell_we0, cell_we1, ship_we0, ship_we1;
    cell_t                  cell_rd0, cell_rd1, cell_wd;
    logic [`SHIP_IDX_W-1:0] ship_idx;
    logic [2*`COORD_W:0]    ship_rd0, ship_rd1, ship_wd;

    // Board address comes from the walker during walks
    assign mem_row = use_walker ? walk_row : cell_row;
    assign mem_col = use_walker ? walk_col : cell_col;

    game_controller ctrl (
        .ph1(ph1), .reset(reset), .read(read), .player(player),
        .direction(direction), .row(row), .col(col),
        .walk_row(walk_row), .walk_col(walk_col),
        .walk_last(walk_last), .walk_busy(walk_busy),
        .cell_rd0(cell_rd0), .cell_rd1(cell_rd1),
        .ship_rd0(ship_rd0), .ship_rd1(ship_rd1),
        .walk_start(walk_start), .walk_stop(walk_stop),
        .walk_dir(walk_dir), .walk_len(walk_len),
        .cell_row(cell_row), .cell_col(cell_col),
        .cell_we0(cell_we0), .cell_we1(cell_we1), .cell_wd(cell_wd),
        .ship_idx(ship_idx), .ship_we0(ship_we0), .ship_we1(ship_we1),
        .ship_wd(ship_wd), .use_walker(use_walker),
        .data_ready(data_ready), .game_over(game_over), .data_out(data_out)
    );

    cell_walker walker (
        .ph1(ph1), .reset(reset), .start(walk_start), .stop(walk_stop),
        .direction(walk_dir), .start_row(cell_row), .start_col(cell_col),
        .length(walk_len), .cur_row(walk_row), .cur_col(walk_col),
        .last(walk_last), .busy(walk_busy)
    );

    board_mem board0 (
        .ph1(ph1), .reset(reset), .write_enable(cell_we0),
        .row(mem_row), .col(mem_col), .write_data(cell_wd), .read_data(cell_rd0)
    );

    board_mem board1 (
        .ph1(ph1), .reset(reset), .write_enable(cell_we1),
        .row(mem_row), .col(mem_col), .write_data(cell_wd), .read_data(cell_rd1)
    );

    ship_store ships0 (
        .ph1(ph1), .reset(reset), .write_enable(ship_we0),
        .ship_idx(ship_idx), .write_data(ship_wd), .read_data(ship_rd0)
    );

    ship_store ships1 (
        .ph1(ph1), .reset(reset), .write_enable(ship_we1),
        .ship_idx(ship_idx), .write_data(ship_wd), .read_data(ship_rd1)
    );

endmodule

`default_nettype wire

// File: verif/battleship_tb.sv
// Battleship referee testbench with board reference model, directed and random moves
`timescale 1ns/100ps
`default_nettype none

`include "battleship_settings.svh"

module battleship_tb
    import battleship_pkg::*;
();

    // 9 + 5 + 9 + 4 + 31 + 3 moves over the six tests
    localparam int NUM_MOVES   = 61;
    localparam int CYCLE_LIMIT = NUM_MOVES * 40 + 200;
    localparam int SIZES [`FLEET_SIZE] = '{`SHIP_SIZE_0, `SHIP_SIZE_1, `SHIP_SIZE_2,
                                           `SHIP_SIZE_3, `SHIP_SIZE_4};

    logic                 ph1, reset, read, player, direction;
    logic [`COORD_W-1:0]  row, col;
    logic                 data_ready, game_over;
    logic [`REPORT_W-1:0] data_out;

    // Reference model of both players
    cell_t m_board  [2][`BOARD_DIM][`BOARD_DIM];
    int    m_ship_r [2][`FLEET_SIZE];
    int    m_ship_c [2][`FLEET_SIZE];
    logic  m_ship_d [2][`FLEET_SIZE];
    int    m_sunk   [2];
    int    m_next;
    logic  m_turn, m_placing, m_over;

    logic [`REPORT_W-1:0] exp_word;
    logic                 pending;
    string                test_name;
    integer               seed;
    int                   last_r [2];
    int                   last_c [2];
    int                   cycles, checks, errors, test_checks, test_errors;

    battleship uut (
        .ph1(ph1), .reset(reset), .read(read), .player(player),
        .direction(direction), .row(row), .col(col),
        .data_ready(data_ready), .game_over(game_over), .data_out(data_out)
    );

    always #10 ph1 = ~ph1;

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    // Ships of board b left without an intact cell once (hr, hc) is hit
    function automatic int sunk_after_hit(input logic b, input int hr, input int hc);
        int   n;
        int   rr;
        int   cc;
        logic intact;
        n = 0;
        for (int s = 0; s < `FLEET_SIZE; s++)
        begin
            intact = 1'b0;
            for (int k = 0; k < SIZES[s]; k++)
            begin
                rr = m_ship_r[b][s] + (m_ship_d[b][s] ? 0 : k);
                cc = m_ship_c[b][s] + (m_ship_d[b][s] ? k : 0);
                if (m_board[b][rr][cc] == CELL_SHIP && !(rr == hr && cc == hc))
                    intact = 1'b1;
            end
            if (!intact)
                n++;
        end
        return n;
    endfunction

    function automatic logic [`REPORT_W-1:0] expected_report(input logic p, input logic d,
                                                               input int r, input int c);
        report_t code;
        logic    tgt;
        logic    sunk;
        int      len;
        code = REPORT_REJECT;
        sunk = 1'b0;
        tgt  = m_placing ? p : !p;
        if (!m_over && p == m_turn && r < `BOARD_DIM && c < `BOARD_DIM)
        begin
            if (m_placing)
            begin
                len = SIZES[m_next];
                // Ship must end on the board and cross only empty water
                if ((d ? c : r) + len <= `BOARD_DIM)
                begin
                    code = REPORT_PLACED;
                    for (int k = 0; k < len; k++)
                        if (m_board[p][d ? r : r + k][d ? c + k : c] != CELL_EMPTY)
                            code = REPORT_REJECT;
                end
            end
            else if (m_board[tgt][r][c] == CELL_EMPTY)
                code = REPORT_MISS;
            else if (m_board[tgt][r][c] == CELL_SHIP)
            begin
                code = REPORT_HIT;
                sunk = sunk_after_hit(tgt, r, c) > m_sunk[tgt];
            end
        end
        return {code, `COORD_W'(r), `COORD_W'(c), tgt, sunk};
    endfunction

    task automatic apply_move(input logic p, input logic d, input int r, input int c,
                              input logic [`REPORT_W-1:0] word);
        report_t code;
        logic    tgt;
        code = report_t'(word[`REPORT_W-1 -: 2]);
        tgt  = m_placing ? p : !p;
        if (code == REPORT_PLACED)
        begin
            for (int k = 0; k < SIZES[m_next]; k++)
                m_board[p][d ? r : r + k][d ? c + k : c] = CELL_SHIP;
            m_ship_r[p][m_next] = r;
            m_ship_c[p][m_next] = c;
            m_ship_d[p][m_next] = d;
            m_next++;
            // Fleet complete, so the other player places or shooting begins
            if (m_next == `FLEET_SIZE)
            begin
                m_next = 0;
                if (m_turn)
                    m_placing = 1'b0;
                m_turn = !m_turn;
            end
        end
        else if (code != REPORT_REJECT)
        begin
            if (code == REPORT_HIT)
            begin
                m_sunk[tgt] = sunk_after_hit(tgt, r, c);
                m_board[tgt][r][c] = CELL_HIT;
                if (m_sunk[tgt] == `FLEET_SIZE)
                    m_over = 1'b1;
            end
            else
                m_board[tgt][r][c] = CELL_MISS;
            m_turn = !m_turn;
        end
    endtask

    task automatic reset_model;
        for (int b = 0; b < 2; b++)
        begin
            m_sunk[b] = 0;
            for (int r = 0; r < `BOARD_DIM; r++)
                for (int c = 0; c < `BOARD_DIM; c++)
                    m_board[b][r][c] = CELL_EMPTY;
        end
        m_next    = 0;
        m_turn    = 1'b0;
        m_placing = 1'b1;
        m_over    = 1'b0;
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic issue_move(input logic p, input logic d, input int r, input int c);
        logic [`REPORT_W-1:0] word;
        @(negedge ph1);
        word      = expected_report(p, d, r, c);
        exp_word  = word;
        pending   = 1'b1;
        read      = 1'b1;
        player    = p;
        direction = d;
        row       = `COORD_W'(r);
        col       = `COORD_W'(c);
        @(negedge ph1);
        read = 1'b0;
        @(negedge ph1);
        while (!data_ready)
            @(negedge ph1);
        // Compare process clears pending once it has checked the report
        wait (!pending);
        apply_move(p, d, r, c, word);
    endtask

    // Shot by player p at a random untouched cell of the other board
    task automatic random_miss(input logic p);
        int r;
        int c;
        do
        begin
            r = $unsigned($random(seed)) % `BOARD_DIM;
            c = $unsigned($random(seed)) % `BOARD_DIM;
        end
        while (m_board[!p][r][c] != CELL_EMPTY);
        last_r[p] = r;
        last_c[p] = c;
        issue_move(p, 1'b0, r, c);
    endtask

    // Player 0 hits every cell of player 1's ship s, player 1 misses in between
    task automatic sink_ship(input int s);
        for (int k = 0; k < SIZES[s]; k++)
        begin
            issue_move(1'b0, 1'b0, m_ship_r[1][s] + (m_ship_d[1][s] ? 0 : k),
                       m_ship_c[1][s] + (m_ship_d[1][s] ? k : 0));
            if (!m_over)
                random_miss(1'b1);
        end
    endtask

    // --------------------------------------------------
    // Checks and reporting
    // --------------------------------------------------
    always @(negedge ph1)
    begin
        if (data_ready && !pending)
        begin
            $display("data_ready pulsed with no move pending during %s", test_name);
            errors++;
            test_errors++;
        end
        else if (data_ready)
        begin
            checks++;
            test_checks++;
            assert (data_out === exp_word)
            else
            begin
                $display("error %s: expected %h actual %h", test_name, exp_word, data_out);
                errors++;
                test_errors++;
            end
            pending = 1'b0;
        end
    end

    task automatic check_level(input string what, input logic expected, input logic actual);
        checks++;
        test_checks++;
        assert (actual === expected)
        else
        begin
            $display("error %s: %s expected %0b actual %0b", test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test;
        $display("%-12s %0d checks, %0d errors", test_name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    always @(posedge ph1)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout, run still going after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        seed        = 32'h853b6e83;
        ph1         = 1'b0;
        reset       = 1'b1;
        read        = 1'b0;
        player      = 1'b0;
        direction   = 1'b0;
        row         = '0;
        col         = '0;
        pending     = 1'b0;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        test_name   = "reset";
        reset_model();
        repeat (5) @(negedge ph1);
        reset = 1'b0;

        // Player 0 fleet, then four ships of player 1
        test_name = "place";
        issue_move(1'b0, 1'b1, 0, 0);
        issue_move(1'b0, 1'b1, 2, 0);
        issue_move(1'b0, 1'b0, 4, 0);
        issue_move(1'b0, 1'b0, 4, 5);
        issue_move(1'b0, 1'b1, 9, 8);
        issue_move(1'b1, 1'b0, 0, 0);
        issue_move(1'b1, 1'b1, 0, 2);
        issue_move(1'b1, 1'b1, 5, 5);
        issue_move(1'b1, 1'b0, 7, 9);
        end_test();

        // Wrong player, past column 9, past row 9, overlap, then a legal retry
        test_name = "place_reject";
        issue_move(1'b0, 1'b1, 9, 0);
        issue_move(1'b1, 1'b1, 3, 9);
        issue_move(1'b1, 1'b0, 9, 3);
        issue_move(1'b1, 1'b1, 0, 3);
        issue_move(1'b1, 1'b1, 8, 0);
        end_test();

        test_name = "miss";
        for (int i = 0; i < 3; i++)
        begin
            random_miss(1'b0);
            random_miss(1'b1);
        end
        issue_move(1'b0, 1'b0, last_r[0], last_c[0]);
        issue_move(1'b1, 1'b0, 3, 3);
        issue_move(1'b0, 1'b0, 12, 3);
        end_test();

        test_name = "hit";
        sink_ship(4);
        end_test();

        test_name = "sink_all";
        for (int s = 0; s < `FLEET_SIZE - 1; s++)
            sink_ship(s);
        check_level("game_over", 1'b1, game_over);
        issue_move(1'b1, 1'b0, 0, 0);
        issue_move(1'b0, 1'b0, 9, 9);
        end_test();

        test_name = "reset";
        @(negedge ph1);
        reset = 1'b1;
        repeat (5) @(negedge ph1);
        reset = 1'b0;
        reset_model();
        check_level("game_over", 1'b0, game_over);
        issue_move(1'b0, 1'b1, 0, 0);
        issue_move(1'b1, 1'b1, 5, 0);
        issue_move(1'b0, 1'b1, 2, 0);
        end_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/battleship_pkg.sv
board/board_mem.sv
board/ship_store.sv
logic/cell_walker.sv
logic/game_controller.sv
logic/battleship.sv
verif/battleship_tb.sv

// File: Makefile
SIM       = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = battleship_tb
FILELIST  = tb.f
BUILD     = obj_dir
LOG       = sim.log
PASS_TEXT = Done: no errors
FAIL_TEXT = Done: errors found

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP), log in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD) $(LOG)
